// File: source/ntm_defines.svh
`ifndef NTM_DEFINES_SVH
`define NTM_DEFINES_SVH

// Vector length of one weighting
`define NTM_SIZE_N 8

// Width of one Q0.8 weight
`define NTM_WORD_W 8

// Gate covers 0 to 256 inclusive
`define NTM_GATE_W 9

// Banks in the weighting buffer
`define NTM_BANKS 2

// Output credits granted after reset
`define NTM_OUT_CREDITS 4

// Fraction bits of weights and taps
`define NTM_FRAC_W 8

`endif

// File: source/ntm_pkg.sv
`default_nettype none

`include "ntm_defines.svh"

package ntm_pkg;

  // Data words
  typedef logic [`NTM_WORD_W-1:0] ntm_word_t;
  typedef logic [`NTM_GATE_W-1:0] ntm_gate_t;

  // Element index and bank select
  typedef logic [$clog2(`NTM_SIZE_N)-1:0] ntm_index_t;
  typedef logic [$clog2(`NTM_BANKS)-1:0] ntm_bank_t;

  // Credit counter holds up to 2N
  typedef logic [$clog2(2 * `NTM_SIZE_N + 1)-1:0] ntm_credit_t;

  // Per bank occupancy
  typedef enum logic [1:0] {bank_empty, bank_filling, bank_full} bank_state_e;

  // Convolver sequencing
  typedef enum logic {conv_idle, conv_run} conv_state_e;

endpackage

`default_nettype wire

// File: source/ntm_interpolator.sv
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defines.svh"

module ntm_interpolator (
  input  logic                CLK,
  input  logic                RST,
  input  logic                in_valid,
  input  ntm_pkg::ntm_word_t  wc_in,
  input  ntm_pkg::ntm_word_t  wprev_in,
  input  ntm_pkg::ntm_gate_t  g_in,
  input  ntm_pkg::ntm_word_t  s_minus_in,
  input  ntm_pkg::ntm_word_t  s_zero_in,
  input  ntm_pkg::ntm_word_t  s_plus_in,
  output logic                in_ready,
  output logic                wr_valid,
  output ntm_pkg::ntm_word_t  wr_data,
  output ntm_pkg::ntm_word_t  wr_s_minus,
  output ntm_pkg::ntm_word_t  wr_s_zero,
  output ntm_pkg::ntm_word_t  wr_s_plus,
  input  logic                credit_return,
  input  ntm_pkg::ntm_credit_t credit_count_return
);

  import ntm_pkg::*;

  // Two full banks worth of credits
  localparam ntm_credit_t credit_max = ntm_credit_t'(2 * `NTM_SIZE_N);
  localparam int prod_w = `NTM_GATE_W + `NTM_WORD_W;

  ntm_credit_t credit_cnt;
  ntm_credit_t credit_cnt_next;
  ntm_gate_t   g_inv;
  logic [prod_w-1:0] blend_sum;
  logic        accept;

  ////////////////////////////////////////////////////////////
  // Credit tracking
  ////////////////////////////////////////////////////////////

  // Output register is a single-cycle pulse so it always drains
  assign in_ready = (credit_cnt != '0);
  assign accept   = in_valid && in_ready;

  // Spend on accept, refill on bank release
  always_comb begin
    credit_cnt_next = credit_cnt;
    if (accept) begin
      credit_cnt_next = credit_cnt_next - ntm_credit_t'(1);
    end
    if (credit_return) begin
      credit_cnt_next = credit_cnt_next + credit_count_return;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credit_cnt <= credit_max;
      wr_valid   <= 1'b0;
    end else begin
      credit_cnt <= credit_cnt_next;
      wr_valid   <= accept;
    end
  end

  ////////////////////////////////////////////////////////////
  // Gated blend
  ////////////////////////////////////////////////////////////

  // Complement gate 256 - g
  assign g_inv = ntm_gate_t'(1 << `NTM_FRAC_W) - g_in;

  // g*wc + (256-g)*wprev never exceeds 256*255
  assign blend_sum = prod_w'(g_in) * prod_w'(wc_in) + prod_w'(g_inv) * prod_w'(wprev_in);

  // Result plus taps for the buffer
  always_ff @(posedge CLK) begin
    if (accept) begin
      wr_data    <= blend_sum[`NTM_FRAC_W +: `NTM_WORD_W];
      wr_s_minus <= s_minus_in;
      wr_s_zero  <= s_zero_in;
      wr_s_plus  <= s_plus_in;
    end
  end

  // Buffer must never hand back more than was spent
  assert property (@(posedge CLK) disable iff (RST) credit_cnt <= credit_max)
    else $error("interpolator credit count above 2N");

endmodule

`default_nettype wire

// File: source/ntm_weighting_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defines.svh"

module ntm_weighting_buffer (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 wr_valid,
  input  ntm_pkg::ntm_word_t   wr_data,
  input  ntm_pkg::ntm_word_t   wr_s_minus,
  input  ntm_pkg::ntm_word_t   wr_s_zero,
  input  ntm_pkg::ntm_word_t   wr_s_plus,
  output logic                 credit_return,
  output ntm_pkg::ntm_credit_t credit_count_return,
  output logic                 rd_bank_full,
  input  ntm_pkg::ntm_index_t  rd_index,
  output ntm_pkg::ntm_word_t   rd_w_prev,
  output ntm_pkg::ntm_word_t   rd_w_cur,
  output ntm_pkg::ntm_word_t   rd_w_next,
  output ntm_pkg::ntm_word_t   rd_s_minus,
  output ntm_pkg::ntm_word_t   rd_s_zero,
  output ntm_pkg::ntm_word_t   rd_s_plus,
  input  logic                 bank_release
);

  import ntm_pkg::*;

  localparam ntm_index_t idx_last  = ntm_index_t'(`NTM_SIZE_N - 1);
  localparam ntm_bank_t  bank_last = ntm_bank_t'(`NTM_BANKS - 1);

  // Storage and per bank taps
  ntm_word_t   mem [`NTM_BANKS][`NTM_SIZE_N];
  ntm_word_t   s_minus_q [`NTM_BANKS];
  ntm_word_t   s_zero_q [`NTM_BANKS];
  ntm_word_t   s_plus_q [`NTM_BANKS];

  bank_state_e bank_state [`NTM_BANKS];
  ntm_bank_t   wr_bank;
  ntm_bank_t   rd_bank;
  ntm_index_t  wr_idx;
  ntm_index_t  idx_prev;
  ntm_index_t  idx_next;

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  // Data lands on the edge after wr_valid
  always_ff @(posedge CLK) begin
    if (wr_valid) begin
      mem[wr_bank][wr_idx] <= wr_data;
      // Taps ride with element 0
      if (wr_idx == '0) begin
        s_minus_q[wr_bank] <= wr_s_minus;
        s_zero_q[wr_bank]  <= wr_s_zero;
        s_plus_q[wr_bank]  <= wr_s_plus;
      end
    end
  end

  // Bank occupancy and pointers
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int b = 0; b < `NTM_BANKS; b++) begin
        bank_state[b] <= bank_empty;
      end
      wr_bank       <= '0;
      wr_idx        <= '0;
      rd_bank       <= '0;
      rd_bank_full  <= 1'b0;
      credit_return <= 1'b0;
    end else begin
      // Consumer done with the read bank
      if (bank_release) begin
        bank_state[rd_bank] <= bank_empty;
        rd_bank <= (rd_bank == bank_last) ? '0 : rd_bank + ntm_bank_t'(1);
      end
      if (wr_valid) begin
        if (wr_idx == idx_last) begin
          bank_state[wr_bank] <= bank_full;
          wr_bank <= (wr_bank == bank_last) ? '0 : wr_bank + ntm_bank_t'(1);
          wr_idx  <= '0;
        end else begin
          bank_state[wr_bank] <= bank_filling;
          wr_idx <= wr_idx + ntm_index_t'(1);
        end
      end
      // Stale flag dropped while the read bank switches
      rd_bank_full  <= !bank_release && (bank_state[rd_bank] == bank_full);
      credit_return <= bank_release;
    end
  end

  // A released bank frees all of its slots
  assign credit_count_return = ntm_credit_t'(`NTM_SIZE_N);

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  // Circular neighbours modulo N
  assign idx_prev = (rd_index == '0) ? idx_last : rd_index - ntm_index_t'(1);
  assign idx_next = (rd_index == idx_last) ? '0 : rd_index + ntm_index_t'(1);

  assign rd_w_prev  = mem[rd_bank][idx_prev];
  assign rd_w_cur   = mem[rd_bank][rd_index];
  assign rd_w_next  = mem[rd_bank][idx_next];
  assign rd_s_minus = s_minus_q[rd_bank];
  assign rd_s_zero  = s_zero_q[rd_bank];
  assign rd_s_plus  = s_plus_q[rd_bank];

  // Producer credits must keep writes off full banks
  assert property (@(posedge CLK) disable iff (RST)
    wr_valid |-> (bank_state[wr_bank] inside {bank_empty, bank_filling}))
    else $error("write into a full bank");

endmodule

`default_nettype wire

// File: source/ntm_shift_convolver.sv
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defines.svh"

module ntm_shift_convolver (
  input  logic                CLK,
  input  logic                RST,
  input  logic                rd_bank_full,
  output ntm_pkg::ntm_index_t rd_index,
  input  ntm_pkg::ntm_word_t  rd_w_prev,
  input  ntm_pkg::ntm_word_t  rd_w_cur,
  input  ntm_pkg::ntm_word_t  rd_w_next,
  input  ntm_pkg::ntm_word_t  rd_s_minus,
  input  ntm_pkg::ntm_word_t  rd_s_zero,
  input  ntm_pkg::ntm_word_t  rd_s_plus,
  output logic                bank_release,
  input  logic                out_credit,
  output logic                w_out_valid,
  output ntm_pkg::ntm_word_t  w_out,
  output ntm_pkg::ntm_index_t w_out_index
);

  import ntm_pkg::*;

  localparam ntm_index_t idx_last = ntm_index_t'(`NTM_SIZE_N - 1);
  // Three 16 bit products need two carry bits
  localparam int sum_w = 2 * `NTM_WORD_W + 2;
  localparam int shr_w = sum_w - `NTM_FRAC_W;

  conv_state_e state;
  ntm_index_t  idx;
  ntm_credit_t credit_cnt;
  logic        fire;
  logic [sum_w-1:0] tap_sum;
  logic [shr_w-1:0] tap_shr;
  ntm_word_t   tap_sat;

  ////////////////////////////////////////////////////////////
  // Three tap circular convolution
  ////////////////////////////////////////////////////////////

  // s_minus pairs with j+1 and s_plus with j-1
  assign tap_sum = sum_w'(rd_s_minus) * sum_w'(rd_w_next)
                 + sum_w'(rd_s_zero) * sum_w'(rd_w_cur)
                 + sum_w'(rd_s_plus) * sum_w'(rd_w_prev);

  assign tap_shr = tap_sum[sum_w-1:`NTM_FRAC_W];

  // Clamp at 255
  assign tap_sat = (|tap_shr[shr_w-1:`NTM_WORD_W]) ? '1 : tap_shr[`NTM_WORD_W-1:0];

  assign rd_index = idx;

  // One result per cycle while credits last
  assign fire = (state == conv_run) && (credit_cnt != '0);

  ////////////////////////////////////////////////////////////
  // Sequencing and credits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= conv_idle;
      idx          <= '0;
      credit_cnt   <= ntm_credit_t'(`NTM_OUT_CREDITS);
      w_out_valid  <= 1'b0;
      bank_release <= 1'b0;
    end else begin
      w_out_valid  <= fire;
      bank_release <= 1'b0;
      // Spend on fire, refill on each returned pulse
      credit_cnt <= credit_cnt - ntm_credit_t'(fire) + ntm_credit_t'(out_credit);
      case (state)
        conv_idle: begin
          // Skip the stale full flag during release
          if (rd_bank_full && !bank_release) begin
            state <= conv_run;
            idx   <= '0;
          end
        end
        conv_run: begin
          if (fire) begin
            if (idx == idx_last) begin
              state        <= conv_idle;
              idx          <= '0;
              bank_release <= 1'b1;
            end else begin
              idx <= idx + ntm_index_t'(1);
            end
          end
        end
        default: state <= conv_idle;
      endcase
    end
  end

  // Result payload
  always_ff @(posedge CLK) begin
    if (fire) begin
      w_out       <= tap_sat;
      w_out_index <= idx;
    end
  end

  // Returned credits never wrap the counter
  assert property (@(posedge CLK) disable iff (RST)
    (out_credit && !fire) |-> (credit_cnt != '1))
    else $error("output credit counter overflow");

endmodule

`default_nettype wire

// File: source/ntm_addressing_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defines.svh"

module ntm_addressing_top (
  input  logic                CLK,
  input  logic                RST,
  input  logic                in_valid,
  input  ntm_pkg::ntm_word_t  wc_in,
  input  ntm_pkg::ntm_word_t  wprev_in,
  input  ntm_pkg::ntm_gate_t  g_in,
  input  ntm_pkg::ntm_word_t  s_minus_in,
  input  ntm_pkg::ntm_word_t  s_zero_in,
  input  ntm_pkg::ntm_word_t  s_plus_in,
  output logic                in_ready,
  input  logic                out_credit,
  output logic                w_out_valid,
  output ntm_pkg::ntm_word_t  w_out,
  output ntm_pkg::ntm_index_t w_out_index
);

  import ntm_pkg::*;

  // Interpolator to buffer
  logic        wr_valid;
  ntm_word_t   wr_data;
  ntm_word_t   wr_s_minus;
  ntm_word_t   wr_s_zero;
  ntm_word_t   wr_s_plus;
  logic        credit_return;
  ntm_credit_t credit_count_return;

  // Buffer to convolver
  logic        rd_bank_full;
  ntm_index_t  rd_index;
  ntm_word_t   rd_w_prev;
  ntm_word_t   rd_w_cur;
  ntm_word_t   rd_w_next;
  ntm_word_t   rd_s_minus;
  ntm_word_t   rd_s_zero;
  ntm_word_t   rd_s_plus;
  logic        bank_release;

  ////////////////////////////////////////////////////////////
  // Producer
  ////////////////////////////////////////////////////////////

  ntm_interpolator ntm_interpolator_inst (
    .CLK                 (CLK),
    .RST                 (RST),
    .in_valid            (in_valid),
    .wc_in               (wc_in),
    .wprev_in            (wprev_in),
    .g_in                (g_in),
    .s_minus_in          (s_minus_in),
    .s_zero_in           (s_zero_in),
    .s_plus_in           (s_plus_in),
    .in_ready            (in_ready),
    .wr_valid            (wr_valid),
    .wr_data             (wr_data),
    .wr_s_minus          (wr_s_minus),
    .wr_s_zero           (wr_s_zero),
    .wr_s_plus           (wr_s_plus),
    .credit_return       (credit_return),
    .credit_count_return (credit_count_return)
  );

  ////////////////////////////////////////////////////////////
  // Two bank store
  ////////////////////////////////////////////////////////////

  ntm_weighting_buffer ntm_weighting_buffer_inst (
    .CLK                 (CLK),
    .RST                 (RST),
    .wr_valid            (wr_valid),
    .wr_data             (wr_data),
    .wr_s_minus          (wr_s_minus),
    .wr_s_zero           (wr_s_zero),
    .wr_s_plus           (wr_s_plus),
    .credit_return       (credit_return),
    .credit_count_return (credit_count_return),
    .rd_bank_full        (rd_bank_full),
    .rd_index            (rd_index),
    .rd_w_prev           (rd_w_prev),
    .rd_w_cur            (rd_w_cur),
    .rd_w_next           (rd_w_next),
    .rd_s_minus          (rd_s_minus),
    .rd_s_zero           (rd_s_zero),
    .rd_s_plus           (rd_s_plus),
    .bank_release        (bank_release)
  );

  // Consumer
  ntm_shift_convolver ntm_shift_convolver_inst (
    .CLK          (CLK),
    .RST          (RST),
    .rd_bank_full (rd_bank_full),
    .rd_index     (rd_index),
    .rd_w_prev    (rd_w_prev),
    .rd_w_cur     (rd_w_cur),
    .rd_w_next    (rd_w_next),
    .rd_s_minus   (rd_s_minus),
    .rd_s_zero    (rd_s_zero),
    .rd_s_plus    (rd_s_plus),
    .bank_release (bank_release),
    .out_credit   (out_credit),
    .w_out_valid  (w_out_valid),
    .w_out        (w_out),
    .w_out_index  (w_out_index)
  );

endmodule

`default_nettype wire

// File: tests/ntm_addressing_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defines.svh"

module ntm_addressing_tb;

  import ntm_pkg::*;

  localparam int num_frames = 3;
  localparam int n_elem     = `NTM_SIZE_N;
  localparam int total      = num_frames * n_elem;
  localparam int wait_limit = 400;
  // Cycles with no output credit returned
  localparam int hold_cycles = 60;

  logic       CLK;
  logic       RST;
  logic       in_valid;
  ntm_word_t  wc_in;
  ntm_word_t  wprev_in;
  ntm_gate_t  g_in;
  ntm_word_t  s_minus_in;
  ntm_word_t  s_zero_in;
  ntm_word_t  s_plus_in;
  logic       in_ready;
  logic       out_credit;
  logic       w_out_valid;
  ntm_word_t  w_out;
  ntm_index_t w_out_index;

  // Frame and element tables from the data file
  int frame_g [num_frames];
  int frame_sm [num_frames];
  int frame_sz [num_frames];
  int frame_sp [num_frames];
  int elem_wc [total];
  int elem_wprev [total];
  int elem_exp [total];

  // Progress shared between processes
  int     accepted = 0;
  int     outputs_seen = 0;
  int     frames_done = 0;
  int     credits_given = 0;
  logic   saw_stall = 1'b0;
  integer seed;

  ntm_addressing_top ntm_addressing_top_inst (
    .CLK         (CLK),
    .RST         (RST),
    .in_valid    (in_valid),
    .wc_in       (wc_in),
    .wprev_in    (wprev_in),
    .g_in        (g_in),
    .s_minus_in  (s_minus_in),
    .s_zero_in   (s_zero_in),
    .s_plus_in   (s_plus_in),
    .in_ready    (in_ready),
    .out_credit  (out_credit),
    .w_out_valid (w_out_valid),
    .w_out       (w_out),
    .w_out_index (w_out_index)
  );

  // 4 ns clock
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_value(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("Error at time %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
      end_with_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////////////////////////

  // Skips blank lines and # comments
  task automatic next_data_line(input int fd, output string line);
    line = "";
    while (line.len() < 2 || line.getc(0) == "#") begin
      if ($feof(fd)) begin
        $display("Stimulus file ended before all frames were read");
        end_with_failure();
      end
      void'($fgets(line, fd));
    end
  endtask

  task automatic load_stimulus();
    int    fd;
    int    f;
    int    e;
    int    k;
    int    a;
    int    b;
    int    c;
    int    d;
    string line;
    fd = $fopen("tests/ntm_stimulus.dat", "r");
    if (fd == 0) begin
      $display("Could not open tests/ntm_stimulus.dat");
      end_with_failure();
    end
    for (f = 0; f < num_frames; f++) begin
      // Gate and taps held for the whole frame
      next_data_line(fd, line);
      if ($sscanf(line, "%d %d %d %d", a, b, c, d) != 4) begin
        $display("Malformed frame header in stimulus file: %s", line);
        end_with_failure();
      end
      frame_g[f]  = a;
      frame_sm[f] = b;
      frame_sz[f] = c;
      frame_sp[f] = d;
      for (e = 0; e < n_elem; e++) begin
        k = f * n_elem + e;
        next_data_line(fd, line);
        if ($sscanf(line, "%d %d %d", a, b, c) != 3) begin
          $display("Malformed element line in stimulus file: %s", line);
          end_with_failure();
        end
        elem_wc[k]    = a;
        elem_wprev[k] = b;
        elem_exp[k]   = c;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////

  // Called at a rising edge, returns at the transfer edge
  task automatic send_element(input int k);
    int f;
    int waited;
    f = k / n_elem;
    in_valid   <= 1'b1;
    wc_in      <= ntm_word_t'(elem_wc[k]);
    wprev_in   <= ntm_word_t'(elem_wprev[k]);
    g_in       <= ntm_gate_t'(frame_g[f]);
    s_minus_in <= ntm_word_t'(frame_sm[f]);
    s_zero_in  <= ntm_word_t'(frame_sz[f]);
    s_plus_in  <= ntm_word_t'(frame_sp[f]);
    waited = 0;
    @(negedge CLK);
    while (!in_ready) begin
      waited++;
      if (waited > wait_limit) begin
        $display("Timeout waiting for in_ready on element %0d", k);
        end_with_failure();
      end
      @(negedge CLK);
    end
    @(posedge CLK);
    accepted++;
  endtask

  initial begin : drive_inputs
    int k;
    int waited;
    RST        = 1'b1;
    in_valid   = 1'b0;
    wc_in      = '0;
    wprev_in   = '0;
    g_in       = '0;
    s_minus_in = '0;
    s_zero_in  = '0;
    s_plus_in  = '0;
    load_stimulus();
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
    // Idle state straight after reset
    @(negedge CLK);
    check_value(int'(in_ready), 1, "in_ready after reset");
    check_value(int'(w_out_valid), 0, "w_out_valid after reset");
    @(posedge CLK);
    for (k = 0; k < total; k++) begin
      send_element(k);
    end
    in_valid <= 1'b0;
    // All frames drained through the convolver
    waited = 0;
    while (frames_done < num_frames) begin
      waited++;
      if (waited > wait_limit) begin
        $display("Timeout waiting for all frames to be output");
        end_with_failure();
      end
      @(negedge CLK);
    end
    // Quiet window so a stray extra result reaches the monitor
    repeat (2 * n_elem) @(negedge CLK);
    if (!saw_stall) begin
      $display("in_ready never dropped while output credits were withheld");
      end_with_failure();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output credits
  ////////////////////////////////////////////////////////////

  initial begin : return_credits
    int gap;
    int rounds;
    out_credit = 1'b0;
    seed   = 55;
    rounds = 0;
    while (RST) begin
      rounds++;
      if (rounds > wait_limit) begin
        $display("Timeout waiting for reset release");
        end_with_failure();
      end
      @(posedge CLK);
    end
    // Starve the convolver so both banks fill
    repeat (hold_cycles) @(posedge CLK);
    rounds = 0;
    while (frames_done < num_frames) begin
      rounds++;
      if (rounds > wait_limit) begin
        $display("Timeout returning output credits");
        end_with_failure();
      end
      gap = $random(seed) & 3;
      repeat (gap) @(posedge CLK);
      @(posedge CLK);
      out_credit <= 1'b1;
      @(posedge CLK);
      // Counted at the edge where the DUT samples the pulse
      credits_given++;
      out_credit <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output and flow control monitor
  ////////////////////////////////////////////////////////////

  always @(negedge CLK) begin : watch_outputs
    int j;
    int f;
    if (!RST && w_out_valid) begin
      check_value(int'(outputs_seen < total), 1, "result beyond the last frame");
      f = outputs_seen / n_elem;
      j = outputs_seen % n_elem;
      check_value(int'(w_out_index), j, $sformatf("w_out_index in frame %0d", f));
      check_value(int'(w_out), elem_exp[outputs_seen],
                  $sformatf("w_out for frame %0d index %0d", f, j));
      outputs_seen++;
      // Never more results than credits granted
      check_value(int'(outputs_seen <= `NTM_OUT_CREDITS + credits_given), 1,
                  "results issued beyond output credits");
      if (j == n_elem - 1) begin
        frames_done++;
      end
    end
    if (!RST) begin
      // At most two banks of backlog
      check_value(int'(accepted - frames_done * n_elem <= 2 * n_elem), 1,
                  "elements accepted beyond two banks of backlog");
      if (!in_ready) begin
        saw_stall = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/ntm_pkg.sv
source/ntm_interpolator.sv
source/ntm_weighting_buffer.sv
source/ntm_shift_convolver.sv
source/ntm_addressing_top.sv
tests/ntm_addressing_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = ntm_addressing_tb
FILELIST = src.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/ntm_stimulus.dat
# Frame header: g s_minus s_zero s_plus
# Element lines, index 0 to 7: wc wprev expected_w_out
256 128 96 32
10 255 20
20 0 28
40 255 57
80 0 115
160 255 170
200 0 145
100 255 87
50 0 36
0 32 0 200
200 8 52
150 16 9
100 24 16
50 32 23
0 40 31
50 48 38
100 56 45
150 64 44
128 200 150 100
255 255 208
0 100 187
100 50 255
255 255 217
30 70 207
200 0 177
0 255 152
90 10 255
